//--- Makefile
VERILATOR ?= verilator
TOP       ?= tbSingleCpu
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

# The binary's exit status is ignored, the log decides
run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "Simulation PASSED" $(LOG); then \
		echo "Run ended without a result, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/tbSingleCpu.sv
`timescale 1ns/100ps
`default_nettype none

module tbSingleCpu;

    localparam int memWords  = 256;
    localparam int maxCycles = 400; // About 70 cycles for six programs and their resets

    logic           CLK;
    logic           arstN;
    rvPkg::word_t   inst;
    rvPkg::word_t   pc;
    rvPkg::wbPort_t wb;

    rvPkg::word_t prog [64];
    rvPkg::word_t modelRegs [32];
    rvPkg::word_t modelMem [memWords];
    rvPkg::word_t modelPc;
    rvPkg::word_t seed;
    int slot;
    int errorCount;
    int testStart;
    int testsRun;
    int testsFailed;
    int cycleCount = 0;

    singleCpu #(
        .dataWords (memWords)
    ) u_singleCpu (
        .CLK   (CLK),
        .arstN (arstN),
        .inst  (inst),
        .pc    (pc),
        .wb    (wb)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= maxCycles) begin
            $display("Timeout: run still going after %0d cycles", maxCycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic rvPkg::word_t nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Instruction encoders take their fields from plain integers
    function automatic rvPkg::word_t rType(int f7b5, int f3, int rd, int rs1, int rs2);
        return {1'b0, f7b5[0], 5'd0, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], rvPkg::OP_REG};
    endfunction

    function automatic rvPkg::word_t iType(rvPkg::opcode_e op, int f3, int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic rvPkg::word_t sType(int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], rvPkg::OP_STORE};
    endfunction

    function automatic rvPkg::word_t bType(int f3, int rs1, int rs2, int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                rvPkg::OP_BRANCH};
    endfunction

    function automatic rvPkg::word_t jType(int rd, int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], rvPkg::OP_JAL};
    endfunction

    task automatic clearProgram();
        for (int i = 0; i < 64; i++) begin
            prog[i] = iType(rvPkg::OP_IMM, 0, 0, 0, i); // addi x0 with the slot number
        end
        slot = 0;
    endtask

    task automatic put(input rvPkg::word_t w);
        prog[slot[5:0]] = w;
        slot++;
    endtask

    task automatic checkWord(input string name, input rvPkg::word_t got, input rvPkg::word_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            errorCount++;
        end
    endtask

    task automatic checkWb(input rvPkg::wbPort_t got, input rvPkg::wbPort_t exp);
        if (got.valid !== exp.valid) begin
            $display("Mismatch wb.valid at pc %h: got %h expected %h", modelPc, got.valid,
                     exp.valid);
            errorCount++;
        end else if (exp.valid) begin
            if (got.rd !== exp.rd) begin
                $display("Mismatch wb.rd at pc %h: got %h expected %h", modelPc, got.rd, exp.rd);
                errorCount++;
            end
            if (got.data !== exp.data) begin
                $display("Mismatch wb.data at pc %h: got %h expected %h", modelPc, got.data,
                         exp.data);
                errorCount++;
            end
        end
    endtask

    // Reference semantics of one instruction at modelPc
    task automatic modelStep(input rvPkg::word_t ins, output rvPkg::wbPort_t expWb,
                             output rvPkg::word_t nextPc);
        rvPkg::word_t a;
        rvPkg::word_t b;
        rvPkg::word_t val;
        rvPkg::word_t addr;
        rvPkg::word_t immI;
        rvPkg::word_t immS;
        rvPkg::word_t immB;
        rvPkg::word_t immJ;
        logic         wr;
        a    = modelRegs[ins[19:15]];
        b    = modelRegs[ins[24:20]];
        immI = {{20{ins[31]}}, ins[31:20]};
        immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        immB = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        immJ = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        wr     = 1'b0;
        val    = '0;
        nextPc = modelPc + 32'd4;
        case (ins[6:0])
            rvPkg::OP_REG: begin
                wr = 1'b1;
                case ({ins[30], ins[14:12]})
                    4'b0000: val = a + b;
                    4'b1000: val = a - b;
                    4'b0001: val = a << b[4:0];
                    4'b0010: val = {31'd0, $signed(a) < $signed(b)};
                    4'b0100: val = a ^ b;
                    4'b0101: val = a >> b[4:0];
                    4'b0110: val = a | b;
                    4'b0111: val = a & b;
                    default: wr = 1'b0;
                endcase
            end
            rvPkg::OP_IMM: begin
                wr = 1'b1;
                case (ins[14:12])
                    3'b000:  val = a + immI;
                    3'b010:  val = {31'd0, $signed(a) < $signed(immI)};
                    3'b100:  val = a ^ immI;
                    3'b110:  val = a | immI;
                    3'b111:  val = a & immI;
                    default: wr = 1'b0;
                endcase
            end
            rvPkg::OP_LOAD: begin
                wr   = 1'b1;
                addr = a + immI;
                val  = modelMem[addr[9:2]]; // 256 words
            end
            rvPkg::OP_STORE: begin
                addr = a + immS;
                modelMem[addr[9:2]] = b;
            end
            rvPkg::OP_BRANCH: begin
                if ((ins[14:12] == 3'b000 && a == b) || (ins[14:12] == 3'b001 && a != b)) begin
                    nextPc = modelPc + immB;
                end
            end
            rvPkg::OP_JAL: begin
                wr     = 1'b1;
                val    = modelPc + 32'd4;
                nextPc = modelPc + immJ;
            end
            default: ;
        endcase
        expWb.valid = wr && (ins[11:7] != 5'd0);
        expWb.rd    = ins[11:7];
        expWb.data  = val;
        if (expWb.valid) begin
            modelRegs[ins[11:7]] = val;
        end
    endtask

    // Entered and left 1 ns after a rising edge
    task automatic applyReset();
        rvPkg::wbPort_t idle;
        idle      = '0;
        testStart = errorCount;
        arstN     = 1'b0;
        repeat (2) begin
            inst = prog[pc[7:2]];
            #2;
            checkWord("pc in reset", pc, '0);
            checkWb(wb, idle);
            @(posedge CLK);
            #1;
        end
        arstN = 1'b1;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        modelPc = '0;
    endtask

    task automatic runProgram(input int steps);
        rvPkg::wbPort_t expWb;
        rvPkg::word_t   nextPc;
        for (int i = 0; i < steps; i++) begin
            inst = prog[pc[7:2]]; // Fetch follows the DUT's own pc
            #2;
            modelStep(prog[modelPc[7:2]], expWb, nextPc);
            checkWord("pc", pc, modelPc);
            checkWb(wb, expWb);
            modelPc = nextPc;
            @(posedge CLK);
            #1;
        end
    endtask

    task automatic finishTest(input string name);
        testsRun++;
        if (errorCount == testStart) begin
            $display("Test %s: ok", name);
        end else begin
            testsFailed++;
            $display("Test %s: %0d errors", name, errorCount - testStart);
        end
    endtask

    task automatic aluRegOps();
        int r1;
        int r2;
        r1 = nextRand();
        r2 = nextRand();
        clearProgram();
        put(iType(rvPkg::OP_IMM, 0, 1, 0, r1));
        put(iType(rvPkg::OP_IMM, 0, 2, 0, r2));
        put(rType(0, 1, 1, 1, 2)); // Spread x1 over more bits
        put(rType(0, 0, 5, 1, 2));
        put(rType(1, 0, 6, 1, 2));
        put(rType(0, 7, 7, 1, 2));
        put(rType(0, 6, 8, 1, 2));
        put(rType(0, 4, 9, 1, 2));
        put(rType(0, 2, 10, 1, 2));
        put(rType(0, 2, 11, 2, 1));
        put(rType(0, 5, 12, 1, 2));
        applyReset();
        runProgram(11);
        finishTest("R-type ALU");
    endtask

    task automatic immSignExt();
        int n[6];
        for (int i = 0; i < 6; i++) begin
            n[i] = nextRand() | 32'h800; // Negative 12-bit immediate
        end
        clearProgram();
        put(iType(rvPkg::OP_IMM, 0, 1, 0, n[0]));
        put(iType(rvPkg::OP_IMM, 0, 2, 1, n[1]));
        put(iType(rvPkg::OP_IMM, 7, 3, 1, n[2]));
        put(iType(rvPkg::OP_IMM, 6, 4, 2, n[3]));
        put(iType(rvPkg::OP_IMM, 4, 5, 1, n[4]));
        put(iType(rvPkg::OP_IMM, 2, 6, 1, n[5]));
        put(iType(rvPkg::OP_IMM, 2, 7, 2, -1));
        put(iType(rvPkg::OP_IMM, 0, 8, 0, -2048));
        applyReset();
        runProgram(8);
        finishTest("I-type sign");
    endtask

    task automatic storeLoad();
        int base;
        base = 256 + int'(nextRand() & 32'hF) * 4;
        clearProgram();
        put(iType(rvPkg::OP_IMM, 0, 1, 0, nextRand()));
        put(iType(rvPkg::OP_IMM, 0, 2, 0, 13));
        put(rType(0, 1, 1, 1, 2));
        put(iType(rvPkg::OP_IMM, 4, 1, 1, nextRand()));
        put(iType(rvPkg::OP_IMM, 0, 4, 1, nextRand()));
        put(rType(1, 0, 5, 0, 1));
        put(iType(rvPkg::OP_IMM, 0, 3, 0, base));
        put(sType(1, 3, 0));
        put(sType(4, 3, 8));
        put(sType(5, 3, -4));
        put(iType(rvPkg::OP_LOAD, 2, 6, 3, -4));
        put(iType(rvPkg::OP_LOAD, 2, 7, 3, 0));
        put(iType(rvPkg::OP_LOAD, 2, 8, 3, 8));
        applyReset();
        runProgram(13);
        finishTest("sw then lw");
    endtask

    task automatic branchPaths();
        clearProgram();
        put(iType(rvPkg::OP_IMM, 0, 1, 0, 5));
        put(iType(rvPkg::OP_IMM, 0, 2, 0, 5));
        put(iType(rvPkg::OP_IMM, 0, 3, 0, 7));
        put(bType(0, 1, 2, 8));  // beq taken
        put(iType(rvPkg::OP_IMM, 0, 10, 0, 1));
        put(bType(0, 1, 3, 8));  // beq not taken
        put(iType(rvPkg::OP_IMM, 0, 11, 0, 2));
        put(bType(1, 1, 3, 8));  // bne taken
        put(iType(rvPkg::OP_IMM, 0, 12, 0, 3));
        put(bType(1, 1, 2, 8));  // bne not taken
        put(iType(rvPkg::OP_IMM, 0, 13, 0, 4));
        put(bType(0, 0, 0, -4)); // Backward loop
        applyReset();
        runProgram(12);
        finishTest("beq and bne");
    endtask

    task automatic jumpLink();
        clearProgram();
        put(iType(rvPkg::OP_IMM, 0, 1, 0, 1));
        put(jType(5, 12));
        put(iType(rvPkg::OP_IMM, 0, 3, 0, 3));
        put(jType(0, 12)); // Link into x0 is dropped
        put(iType(rvPkg::OP_IMM, 0, 2, 0, 2));
        put(jType(6, -12));
        put(rType(0, 0, 7, 5, 6));
        applyReset();
        runProgram(7);
        finishTest("jal");
    endtask

    task automatic zeroReg();
        clearProgram();
        put(iType(rvPkg::OP_IMM, 0, 0, 0, 123));
        put(iType(rvPkg::OP_IMM, 0, 1, 0, nextRand()));
        put(rType(0, 0, 0, 1, 1));
        put(rType(0, 0, 2, 0, 1));
        put(rType(0, 0, 3, 1, 0));
        applyReset();
        runProgram(5);
        finishTest("x0 and reset");
    endtask

    initial begin
        seed        = 32'h24e6a1a5;
        errorCount  = 0;
        testsRun    = 0;
        testsFailed = 0;
        arstN       = 1'b0;
        inst        = '0;
        clearProgram();
        @(posedge CLK);
        #1;
        aluRegOps();
        immSignExt();
        storeLoad();
        branchPaths();
        jumpLink();
        zeroReg();
        $display("Tests run %0d, failed %0d, mismatches %0d", testsRun, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
verilog/rvPkg.sv
verilog/alu.sv
verilog/immGen.sv
verilog/regFile.sv
verilog/dataMem.sv
verilog/pcUnit.sv
verilog/mainControl.sv
verilog/singleCpu.sv
bench/tbSingleCpu.sv

//--- verilog/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  rvPkg::word_t  a,
    input  rvPkg::word_t  b,
    input  rvPkg::aluOp_e op,
    output rvPkg::word_t  result,
    output logic          zero
);

    logic [4:0] shamt;
    logic       lessThan;

    assign shamt    = b[4:0];
    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            rvPkg::ALU_ADD: result = a + b;
            rvPkg::ALU_SUB: result = a - b;
            rvPkg::ALU_AND: result = a & b;
            rvPkg::ALU_OR:  result = a | b;
            rvPkg::ALU_XOR: result = a ^ b;
            rvPkg::ALU_SLT: result = {31'd0, lessThan};
            rvPkg::ALU_SLL: result = a << shamt;
            rvPkg::ALU_SRL: result = a >> shamt;
            default:        result = a + b;
        endcase
    end

    // Used by beq and bne after a subtract
    assign zero = (result == '0);

    always_comb begin
        if (!$isunknown({a, b, op})) begin
            assert (!$isunknown(result))
                else $error("alu: unknown result for op %h", op);
        end
    end

endmodule

`default_nettype wire

//--- verilog/dataMem.sv
`timescale 1ns/100ps
`default_nettype none

module dataMem #(
    parameter int dataWords = 256
) (
    input  wire          CLK,
    input  wire          we,
    input  rvPkg::word_t addr,
    input  rvPkg::word_t wd,
    output rvPkg::word_t rd
);

    localparam int idxW = $clog2(dataWords);

    rvPkg::word_t    mem [dataWords];
    logic [idxW-1:0] idx;

    // Word index, byte offset dropped
    assign idx = addr[idxW+1:2];

    assign rd = mem[idx];

    always_ff @(posedge CLK) begin
        if (we) begin
            mem[idx] <= wd;
        end
    end

    // Out-of-range stores would alias onto low words
    storeInRange: assert property (
        @(posedge CLK) we |-> (addr[1:0] == 2'b00)
                           && (addr < rvPkg::word_t'(dataWords * 4))
    ) else $error("dataMem: bad store address %h", addr);

endmodule

`default_nettype wire

//--- verilog/immGen.sv
`timescale 1ns/100ps
`default_nettype none

module immGen (
    input  rvPkg::word_t    inst,
    input  rvPkg::immKind_e immKind,
    output rvPkg::word_t    imm
);

    rvPkg::word_t immI;
    rvPkg::word_t immS;
    rvPkg::word_t immB;
    rvPkg::word_t immJ;

    // Sign bit is always inst[31]
    assign immI = {{20{inst[31]}}, inst[31:20]};

    assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};

    // Branch offset in halfwords
    assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                   inst[11:8], 1'b0};

    assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                   inst[30:21], 1'b0};

    always_comb begin
        case (immKind)
            rvPkg::IMM_I: imm = immI;
            rvPkg::IMM_S: imm = immS;
            rvPkg::IMM_B: imm = immB;
            rvPkg::IMM_J: imm = immJ;
            default:      imm = immI;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/mainControl.sv
`timescale 1ns/100ps
`default_nettype none

module mainControl (
    input  wire          arstN,
    input  rvPkg::word_t inst,
    output rvPkg::ctrl_t ctrl
);

    rvPkg::opcode_e opcode;
    logic [2:0]     funct3;
    logic           funct7b5;
    rvPkg::ctrl_t   dec;

    assign opcode   = rvPkg::opcode_e'(inst[6:0]);
    assign funct3   = inst[14:12];
    assign funct7b5 = inst[30];

    always_comb begin
        dec           = '0;
        dec.aluOp     = rvPkg::ALU_ADD;
        dec.immKind   = rvPkg::IMM_I;
        case (opcode)
            rvPkg::OP_REG: begin
                dec.regWrite = 1'b1;
                case ({funct7b5, funct3})
                    4'b0000: dec.aluOp = rvPkg::ALU_ADD;
                    4'b1000: dec.aluOp = rvPkg::ALU_SUB;
                    4'b0001: dec.aluOp = rvPkg::ALU_SLL;
                    4'b0010: dec.aluOp = rvPkg::ALU_SLT;
                    4'b0100: dec.aluOp = rvPkg::ALU_XOR;
                    4'b0101: dec.aluOp = rvPkg::ALU_SRL;
                    4'b0110: dec.aluOp = rvPkg::ALU_OR;
                    4'b0111: dec.aluOp = rvPkg::ALU_AND;
                    default: dec.regWrite = 1'b0; // sra, sltu etc. become no-ops
                endcase
            end
            rvPkg::OP_IMM: begin
                dec.regWrite  = 1'b1;
                dec.aluSrcImm = 1'b1;
                // funct7 is part of the immediate here
                case (funct3)
                    3'b000:  dec.aluOp = rvPkg::ALU_ADD;
                    3'b010:  dec.aluOp = rvPkg::ALU_SLT;
                    3'b100:  dec.aluOp = rvPkg::ALU_XOR;
                    3'b110:  dec.aluOp = rvPkg::ALU_OR;
                    3'b111:  dec.aluOp = rvPkg::ALU_AND;
                    default: dec.regWrite = 1'b0;
                endcase
            end
            rvPkg::OP_LOAD: begin
                dec.regWrite  = 1'b1;
                dec.memToReg  = 1'b1;
                dec.aluSrcImm = 1'b1;
            end
            rvPkg::OP_STORE: begin
                dec.memWrite  = 1'b1;
                dec.aluSrcImm = 1'b1;
                dec.immKind   = rvPkg::IMM_S;
            end
            rvPkg::OP_BRANCH: begin
                dec.branch   = (funct3[2:1] == 2'b00); // beq and bne only
                dec.branchNe = funct3[0];
                dec.aluOp    = rvPkg::ALU_SUB;
                dec.immKind  = rvPkg::IMM_B;
            end
            rvPkg::OP_JAL: begin
                dec.regWrite = 1'b1;
                dec.jump     = 1'b1;
                dec.immKind  = rvPkg::IMM_J;
            end
            default: ; // Unknown opcode falls through as a no-op
        endcase
    end

    // No architectural writes while in reset
    always_comb begin
        ctrl          = dec;
        ctrl.regWrite = dec.regWrite & arstN;
        ctrl.memWrite = dec.memWrite & arstN;
    end

    always_comb begin
        assert (!(ctrl.memWrite && ctrl.regWrite))
            else $error("mainControl: memWrite and regWrite both high");
    end

endmodule

`default_nettype wire

//--- verilog/pcUnit.sv
`timescale 1ns/100ps
`default_nettype none

module pcUnit (
    input  wire          CLK,
    input  wire          arstN,
    input  rvPkg::ctrl_t ctrl,
    input  wire          zero,
    input  rvPkg::word_t imm,
    output rvPkg::word_t pc,
    output rvPkg::word_t pcPlus4
);

    rvPkg::word_t target;
    rvPkg::word_t pcNext;
    logic         takeTarget;

    assign pcPlus4 = pc + 32'd4;
    assign target  = pc + imm; // Shared by branches and jal

    // Branch condition from the subtract result
    assign takeTarget = ctrl.jump | (ctrl.branch & (zero != ctrl.branchNe));

    assign pcNext = takeTarget ? target : pcPlus4;

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    // Immediates of B and J have bit 0 clear, bit 1 could still break alignment
    pcAligned: assert property (
        @(posedge CLK) disable iff (!arstN) pc[1:0] == 2'b00
    ) else $error("pcUnit: misaligned pc %h", pc);

endmodule

`default_nettype wire

//--- verilog/regFile.sv
`timescale 1ns/100ps
`default_nettype none

module regFile (
    input  wire             CLK,
    input  wire             arstN,
    input  rvPkg::regAddr_t rs1,
    input  rvPkg::regAddr_t rs2,
    input  rvPkg::regAddr_t rd,
    input  wire             we,
    input  rvPkg::word_t    wd,
    output rvPkg::word_t    rd1,
    output rvPkg::word_t    rd2
);

    rvPkg::word_t regs [32];

    // Asynchronous read ports
    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin // x0 is hardwired
            regs[rd] <= wd;
        end
    end

    // Reads of x0 depend on this entry never changing
    x0Zero: assert property (
        @(posedge CLK) disable iff (!arstN) regs[0] == '0
    ) else $error("regFile: x0 holds %h", regs[0]);

endmodule

`default_nettype wire

//--- verilog/rvPkg.sv
`default_nettype none

package rvPkg;

    // Data word, address and instruction width
    typedef logic [31:0] word_t;

    // Register index
    typedef logic [4:0] regAddr_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } opcode_e;

    // Encoded as {funct7[5], funct3} of the R-type form
    typedef enum logic [3:0] {
        ALU_ADD = 4'b0000,
        ALU_SUB = 4'b1000,
        ALU_SLL = 4'b0001,
        ALU_SLT = 4'b0010,
        ALU_XOR = 4'b0100,
        ALU_SRL = 4'b0101,
        ALU_OR  = 4'b0110,
        ALU_AND = 4'b0111
    } aluOp_e;

    // Immediate formats
    typedef enum logic [1:0] {
        IMM_I = 2'd0,
        IMM_S = 2'd1,
        IMM_B = 2'd2,
        IMM_J = 2'd3
    } immKind_e;

    typedef struct packed {
        logic     regWrite;
        logic     memWrite;
        logic     memToReg;  // Load data to rd
        logic     aluSrcImm; // ALU operand b from immediate
        logic     branch;
        logic     branchNe;  // Taken on not-zero
        logic     jump;
        aluOp_e   aluOp;
        immKind_e immKind;
    } ctrl_t;

    // Register write-back seen at the top level
    typedef struct packed {
        logic     valid;
        regAddr_t rd;
        word_t    data;
    } wbPort_t;

endpackage

`default_nettype wire

//--- verilog/singleCpu.sv
`timescale 1ns/100ps
`default_nettype none

module singleCpu #(
    parameter int dataWords = 256
) (
    input  wire           CLK,
    input  wire           arstN,
    input  rvPkg::word_t  inst,
    output rvPkg::word_t  pc,
    output rvPkg::wbPort_t wb
);

    rvPkg::ctrl_t    ctrl;
    rvPkg::regAddr_t rs1Idx;
    rvPkg::regAddr_t rs2Idx;
    rvPkg::regAddr_t rdIdx;
    rvPkg::word_t    rs1Data;
    rvPkg::word_t    rs2Data;
    rvPkg::word_t    imm;
    rvPkg::word_t    aluB;
    rvPkg::word_t    aluResult;
    logic            aluZero;
    rvPkg::word_t    memRdata;
    rvPkg::word_t    pcPlus4;
    rvPkg::word_t    wbData;

    // Register fields of the instruction
    assign rs1Idx = inst[19:15];
    assign rs2Idx = inst[24:20];
    assign rdIdx  = inst[11:7];

    assign aluB = ctrl.aluSrcImm ? imm : rs2Data;

    // Link address has priority over load data
    assign wbData = ctrl.jump     ? pcPlus4  :
                    ctrl.memToReg ? memRdata : aluResult;

    assign wb.valid = ctrl.regWrite && (rdIdx != '0);
    assign wb.rd    = rdIdx;
    assign wb.data  = wbData;

    mainControl u_mainControl (
        .arstN (arstN),
        .inst  (inst),
        .ctrl  (ctrl)
    );

    pcUnit u_pcUnit (
        .CLK     (CLK),
        .arstN   (arstN),
        .ctrl    (ctrl),
        .zero    (aluZero),
        .imm     (imm),
        .pc      (pc),
        .pcPlus4 (pcPlus4)
    );

    regFile u_regFile (
        .CLK   (CLK),
        .arstN (arstN),
        .rs1   (rs1Idx),
        .rs2   (rs2Idx),
        .rd    (rdIdx),
        .we    (ctrl.regWrite),
        .wd    (wbData),
        .rd1   (rs1Data),
        .rd2   (rs2Data)
    );

    immGen u_immGen (
        .inst    (inst),
        .immKind (ctrl.immKind),
        .imm     (imm)
    );

    alu u_alu (
        .a      (rs1Data),
        .b      (aluB),
        .op     (ctrl.aluOp),
        .result (aluResult),
        .zero   (aluZero)
    );

    dataMem #(
        .dataWords (dataWords)
    ) u_dataMem (
        .CLK  (CLK),
        .we   (ctrl.memWrite),
        .addr (aluResult),
        .wd   (rs2Data),
        .rd   (memRdata)
    );

endmodule

`default_nettype wire
